/* rtl/chroni_cfg_pkg.sv */
package chroni_cfg_pkg;

   // register offsets on the cpu write port
   localparam logic [3:0] REG_CHARSET      = 4'h2;
   localparam logic [3:0] REG_PAL_INDEX    = 4'h4;
   localparam logic [3:0] REG_PAL_DATA     = 4'h5;  // low byte then high byte
   localparam logic [3:0] REG_VRAM_ADDR_LO = 4'h6;
   localparam logic [3:0] REG_VRAM_ADDR_HI = 4'h7;
   localparam logic [3:0] REG_VRAM_DATA    = 4'h9;  // autoincrementing data port

   // default sizes, the top level may override them
   localparam int DEF_LINE_CHARS = 8;
   localparam int DEF_VRAM_AW    = 12;

   localparam int PAL_IW     = 4;   // 16 palette entries
   localparam int COLOR_W    = 16;
   localparam int GLYPH_ROWS = 8;   // scanlines per glyph

endpackage

/* rtl/chroni_types_pkg.sv */
package chroni_types_pkg;

   typedef struct packed {
      logic [3:0] offset;
      logic [7:0] data;
      logic       wr_en;
   } cpu_wr_t;

   // addresses wider than the vram are truncated by the renderer
   typedef struct packed {
      logic [15:0] text_addr;
      logic [15:0] attr_addr;
      logic [2:0]  scan;
   } line_req_t;

   typedef struct packed {
      logic [7:0]                         bits;
      logic [chroni_cfg_pkg::PAL_IW-1:0]  on_idx;
      logic [chroni_cfg_pkg::PAL_IW-1:0]  off_idx;
      logic                               last;   // last character of the row
   } glyph_t;

   typedef struct packed {
      logic [chroni_cfg_pkg::PAL_IW-1:0]  idx;
      logic [chroni_cfg_pkg::COLOR_W-1:0] color;
      logic                               en;
   } pal_wr_t;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  data;
      logic        en;
   } vram_wr_t;

   typedef struct packed {
      logic [chroni_cfg_pkg::COLOR_W-1:0] color;
      logic                               last;
   } pix_out_t;

endpackage

/* rtl/chroni_regs.sv */
`timescale 1ns/1ps

module chroni_regs #(
   parameter int VRAM_AW = chroni_cfg_pkg::DEF_VRAM_AW
) (
   input  logic                       sys_clk,
   input  logic                       rst_n,
   input  chroni_types_pkg::cpu_wr_t  cpu,
   output chroni_types_pkg::vram_wr_t vram_wr,
   output chroni_types_pkg::pal_wr_t  pal_wr,
   output logic [7:0]                 charset_base
);
   import chroni_cfg_pkg::*;

   typedef enum logic [1:0] {
      PAL_LO,
      PAL_HI,
      PAL_WRITE
   } pal_state_t;

   pal_state_t         pal_state;
   logic [PAL_IW-1:0]  pal_index;
   logic [COLOR_W-1:0] pal_value;
   logic [VRAM_AW-1:0] vram_addr;   // next data port address

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         pal_state    <= PAL_LO;
         pal_index    <= '0;
         pal_value    <= '0;
         vram_addr    <= '0;
         vram_wr      <= '0;
         pal_wr       <= '0;
         charset_base <= '0;
      end else begin
         vram_wr.en <= 1'b0;
         pal_wr.en  <= 1'b0;
         if (cpu.wr_en) begin
            case (cpu.offset)
               REG_CHARSET:
                  charset_base <= cpu.data;
               REG_PAL_INDEX: begin
                  pal_index <= cpu.data[PAL_IW-1:0];
                  pal_state <= PAL_LO;   // restart the byte pair
               end
               REG_PAL_DATA: begin
                  if (pal_state == PAL_LO) begin
                     pal_value[7:0] <= cpu.data;
                     pal_state      <= PAL_HI;
                  end else begin
                     pal_value[COLOR_W-1:8] <= cpu.data;
                     pal_state              <= PAL_WRITE;
                  end
               end
               REG_VRAM_ADDR_LO:
                  vram_addr[7:0] <= cpu.data;
               REG_VRAM_ADDR_HI:
                  vram_addr <= VRAM_AW'({cpu.data, vram_addr[7:0]});
               REG_VRAM_DATA: begin
                  vram_wr.en   <= 1'b1;
                  vram_wr.addr <= 16'(vram_addr);
                  vram_wr.data <= cpu.data;
                  vram_addr    <= vram_addr + 1'b1;
               end
               default: ;
            endcase
         end else if (pal_state == PAL_WRITE) begin
            // commit on a quiet port cycle
            pal_wr.en    <= 1'b1;
            pal_wr.idx   <= pal_index;
            pal_wr.color <= pal_value;
            pal_index    <= pal_index + 1'b1;
            pal_state    <= PAL_LO;
         end
      end
   end

   // a finished byte pair reaches the palette right after the next quiet port cycle
   assert property (@(posedge sys_clk) disable iff (!rst_n)
         (cpu.wr_en && cpu.offset == REG_PAL_DATA && pal_state == PAL_HI) ##1 !cpu.wr_en
            |=> (pal_wr.en && pal_wr.color[COLOR_W-1:8] == $past(cpu.data, 2)))
      else $error("palette pair not written after the quiet cycle");

endmodule

/* rtl/vram.sv */
`timescale 1ns/1ps

module vram #(
   parameter int VRAM_AW = chroni_cfg_pkg::DEF_VRAM_AW
) (
   input  logic                       sys_clk,
   input  chroni_types_pkg::vram_wr_t wr,
   input  logic [VRAM_AW-1:0]         rd_addr,
   output logic [7:0]                 rd_data
);

   logic [7:0] mem [2**VRAM_AW];

   always_ff @(posedge sys_clk) begin
      if (wr.en) begin
         mem[wr.addr[VRAM_AW-1:0]] <= wr.data;   // upper address bits ignored
      end
   end

   // registered read, data one cycle after the address
   always_ff @(posedge sys_clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* rtl/glyph_fetch.sv */
`timescale 1ns/1ps

module glyph_fetch #(
   parameter int LINE_CHARS = chroni_cfg_pkg::DEF_LINE_CHARS,
   parameter int VRAM_AW    = chroni_cfg_pkg::DEF_VRAM_AW
) (
   input  logic                        sys_clk,
   input  logic                        rst_n,
   input  chroni_types_pkg::line_req_t req,
   input  logic                        req_valid,
   output logic                        req_ready,
   input  logic [7:0]                  charset_base,
   output logic [VRAM_AW-1:0]          rd_addr,
   input  logic [7:0]                  rd_data,
   output chroni_types_pkg::glyph_t    glyph,
   output logic                        glyph_valid,
   input  logic                        glyph_ready
);
   import chroni_cfg_pkg::*;

   localparam int IW = (LINE_CHARS > 1) ? $clog2(LINE_CHARS) : 1;
   localparam int GW = 18;   // holds base*1024 + code*8 + scan

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_TEXT_RD,
      ST_ATTR_RD,
      ST_FONT_RD,
      ST_FONT_WAIT,
      ST_FONT_WRITE
   } state_t;

   state_t             state;
   logic [IW-1:0]      idx;
   logic               last_char;
   logic [VRAM_AW-1:0] text_base;
   logic [VRAM_AW-1:0] attr_base;
   logic [2:0]         scan;
   logic [7:0]         text_buf [LINE_CHARS];
   logic [7:0]         attr_buf [LINE_CHARS];
   logic               cap_en;     // read data of last cycle goes to a buffer
   logic               cap_attr;
   logic [IW-1:0]      cap_idx;
   logic [GW-1:0]      glyph_addr;

   assign req_ready = (state == ST_IDLE);
   assign last_char = (idx == IW'(LINE_CHARS - 1));

   assign glyph_addr = (GW'(charset_base) << 10) + GW'(text_buf[idx]) * GW'(GLYPH_ROWS)
                       + GW'(scan);

   always_comb begin
      case (state)
         ST_TEXT_RD: rd_addr = text_base + VRAM_AW'(idx);
         ST_ATTR_RD: rd_addr = attr_base + VRAM_AW'(idx);
         default:    rd_addr = glyph_addr[VRAM_AW-1:0];   // wraps at vram size
      endcase
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= ST_IDLE;
         idx         <= '0;
         cap_en      <= 1'b0;
         glyph_valid <= 1'b0;
      end else begin
         cap_en <= 1'b0;
         case (state)
            ST_IDLE:
               if (req_valid) begin
                  idx   <= '0;
                  state <= ST_TEXT_RD;
               end
            ST_TEXT_RD: begin
               cap_en <= 1'b1;
               if (last_char) begin
                  idx   <= '0;
                  state <= ST_ATTR_RD;
               end else begin
                  idx <= idx + 1'b1;
               end
            end
            ST_ATTR_RD: begin
               cap_en <= 1'b1;
               if (last_char) begin
                  idx   <= '0;
                  state <= ST_FONT_RD;
               end else begin
                  idx <= idx + 1'b1;
               end
            end
            ST_FONT_RD:
               state <= ST_FONT_WAIT;   // glyph byte is on rd_data next cycle
            ST_FONT_WAIT: begin
               glyph_valid <= 1'b1;
               state       <= ST_FONT_WRITE;
            end
            ST_FONT_WRITE:
               if (glyph_ready) begin
                  glyph_valid <= 1'b0;
                  if (last_char) begin
                     state <= ST_IDLE;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= ST_FONT_RD;
                  end
               end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (req_valid && req_ready) begin
         text_base <= req.text_addr[VRAM_AW-1:0];
         attr_base <= req.attr_addr[VRAM_AW-1:0];
         scan      <= req.scan;
      end
      cap_attr <= (state == ST_ATTR_RD);
      cap_idx  <= idx;
      if (cap_en) begin
         if (cap_attr) begin
            attr_buf[cap_idx] <= rd_data;
         end else begin
            text_buf[cap_idx] <= rd_data;
         end
      end
      if (state == ST_FONT_WAIT) begin
         glyph.bits    <= rd_data;
         glyph.on_idx  <= attr_buf[idx][PAL_IW-1:0];          // low nibble for set bits
         glyph.off_idx <= attr_buf[idx][2*PAL_IW-1:PAL_IW];
         glyph.last    <= last_char;
      end
   end

   // no new row is taken until the last glyph of the current one has left
   assert property (@(posedge sys_clk) disable iff (!rst_n)
         (req_valid && req_ready) |=>
            (!req_ready until_with (glyph_valid && glyph_ready && glyph.last)))
      else $error("request port reopened before the row finished");

endmodule

/* rtl/palette_shader.sv */
`timescale 1ns/1ps

module palette_shader (
   input  logic                       sys_clk,
   input  logic                       rst_n,
   input  chroni_types_pkg::pal_wr_t  pal_wr,
   input  chroni_types_pkg::glyph_t   glyph,
   input  logic                       glyph_valid,
   output logic                       glyph_ready,
   output chroni_types_pkg::pix_out_t pix,
   output logic                       pix_valid,
   input  logic                       pix_ready
);
   import chroni_cfg_pkg::*;

   logic [COLOR_W-1:0] palette [2**PAL_IW];
   logic [7:0]         shift;       // msb is the current pixel
   logic [3:0]         bits_left;
   logic [PAL_IW-1:0]  on_idx;
   logic [PAL_IW-1:0]  off_idx;
   logic               row_last;

   always_ff @(posedge sys_clk) begin
      if (pal_wr.en) begin
         palette[pal_wr.idx] <= pal_wr.color;
      end
   end

   assign glyph_ready = (bits_left == 4'd0);
   assign pix_valid   = (bits_left != 4'd0);

   always_comb begin
      pix.color = palette[shift[7] ? on_idx : off_idx];
      pix.last  = row_last && (bits_left == 4'd1);
   end

   always_ff @(posedge sys_clk or negedge rst_n) begin
      if (!rst_n) begin
         bits_left <= 4'd0;
      end else if (glyph_valid && glyph_ready) begin
         bits_left <= 4'd8;
      end else if (pix_valid && pix_ready) begin
         bits_left <= bits_left - 1'b1;
      end
   end

   always_ff @(posedge sys_clk) begin
      if (glyph_valid && glyph_ready) begin
         shift    <= glyph.bits;
         on_idx   <= glyph.on_idx;
         off_idx  <= glyph.off_idx;
         row_last <= glyph.last;
      end else if (pix_valid && pix_ready) begin
         shift <= {shift[6:0], 1'b0};
      end
   end

   // a stalled pixel stays put until it is taken
   assert property (@(posedge sys_clk) disable iff (!rst_n)
         (pix_valid && !pix_ready) |=> (pix_valid && $stable(pix)))
      else $error("pix changed while stalled");

endmodule

/* rtl/chroni_text.sv */
`timescale 1ns/1ps

module chroni_text #(
   parameter int LINE_CHARS = chroni_cfg_pkg::DEF_LINE_CHARS,
   parameter int VRAM_AW    = chroni_cfg_pkg::DEF_VRAM_AW
) (
   input  logic                        sys_clk,
   input  logic                        rst_n,
   input  chroni_types_pkg::cpu_wr_t   cpu,
   input  chroni_types_pkg::line_req_t req,
   input  logic                        req_valid,
   output logic                        req_ready,
   output chroni_types_pkg::pix_out_t  pix,
   output logic                        pix_valid,
   input  logic                        pix_ready
);
   import chroni_types_pkg::*;

   vram_wr_t           vram_wr;
   pal_wr_t            pal_wr;
   glyph_t             glyph;
   logic               glyph_valid;
   logic               glyph_ready;
   logic [7:0]         charset_base;
   logic [VRAM_AW-1:0] rd_addr;
   logic [7:0]         rd_data;

   chroni_regs #(
      .VRAM_AW (VRAM_AW)
   ) chroni_regs_i (
      .sys_clk      (sys_clk),
      .rst_n        (rst_n),
      .cpu          (cpu),
      .vram_wr      (vram_wr),
      .pal_wr       (pal_wr),
      .charset_base (charset_base)
   );

   vram #(
      .VRAM_AW (VRAM_AW)
   ) vram_i (
      .sys_clk (sys_clk),
      .wr      (vram_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   glyph_fetch #(
      .LINE_CHARS (LINE_CHARS),
      .VRAM_AW    (VRAM_AW)
   ) glyph_fetch_i (
      .sys_clk      (sys_clk),
      .rst_n        (rst_n),
      .req          (req),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .charset_base (charset_base),
      .rd_addr      (rd_addr),
      .rd_data      (rd_data),
      .glyph        (glyph),
      .glyph_valid  (glyph_valid),
      .glyph_ready  (glyph_ready)
   );

   palette_shader palette_shader_i (
      .sys_clk     (sys_clk),
      .rst_n       (rst_n),
      .pal_wr      (pal_wr),
      .glyph       (glyph),
      .glyph_valid (glyph_valid),
      .glyph_ready (glyph_ready),
      .pix         (pix),
      .pix_valid   (pix_valid),
      .pix_ready   (pix_ready)
   );

endmodule

/* include/chroni_tb_tasks.svh */
`ifndef CHRONI_TB_TASKS_SVH
`define CHRONI_TB_TASKS_SVH

// one register write per cycle, the model follows the register rules
task automatic write_reg(input logic [3:0] offset, input logic [7:0] data);
   @(negedge sys_clk);
   cpu = '{offset, data, 1'b1};
   case (offset)
      REG_CHARSET:
         charset_model = data;
      REG_PAL_INDEX: begin
         pal_ptr     = data[PAL_IW-1:0];
         pal_hi_next = 1'b0;
      end
      REG_PAL_DATA:
         if (!pal_hi_next) begin
            pal_lo      = data;
            pal_hi_next = 1'b1;
         end else begin
            pal_model[pal_ptr] = {data, pal_lo};
            pal_ptr            = pal_ptr + 1'b1;
            pal_hi_next        = 1'b0;
         end
      REG_VRAM_ADDR_LO:
         vram_ptr[7:0] = data;
      REG_VRAM_ADDR_HI:
         vram_ptr = AW'({data, vram_ptr[7:0]});
      REG_VRAM_DATA: begin
         vram_model[vram_ptr] = data;
         vram_ptr             = vram_ptr + 1'b1;   // data port autoincrement
      end
      default: ;
   endcase
endtask

task automatic bus_idle();
   @(negedge sys_clk);
   cpu = '0;
endtask

task automatic set_vram_addr(input logic [15:0] addr);
   write_reg(REG_VRAM_ADDR_LO, addr[7:0]);
   write_reg(REG_VRAM_ADDR_HI, addr[15:8]);
endtask

// low byte, high byte, then a quiet cycle for the commit
task automatic write_pal_pair(input logic [15:0] color);
   write_reg(REG_PAL_DATA, color[7:0]);
   write_reg(REG_PAL_DATA, color[15:8]);
   bus_idle();
endtask

task automatic fill_vram();
   int r;
   set_vram_addr(16'h0000);
   for (int i = 0; i < 2**AW; i++) begin
      r = $random(seed);
      write_reg(REG_VRAM_DATA, r[7:0]);
   end
   bus_idle();
endtask

function automatic pix_out_t expected_pix(input int n);
   logic [AW-1:0] code_addr;
   logic [AW-1:0] attr_addr;
   logic [AW-1:0] font_addr;
   logic [7:0]    code;
   logic [7:0]    attr;
   logic [7:0]    gbits;
   pix_out_t      p;
   code_addr = AW'(row_text) + AW'(n / 8);
   attr_addr = AW'(row_attr) + AW'(n / 8);
   code      = vram_model[code_addr];
   attr      = vram_model[attr_addr];
   font_addr = AW'(32'(charset_model) * 1024 + 32'(code) * 8 + 32'(row_scan));
   gbits     = vram_model[font_addr];
   p.color   = gbits[7 - (n % 8)] ? pal_model[attr[3:0]] : pal_model[attr[7:4]];
   p.last    = (n == 8 * LC - 1);
   return p;
endfunction

task automatic check_pix(input int n, input pix_out_t got, input pix_out_t exp);
   if (got !== exp) begin
      mismatch_count++;
      $display("mismatch pix[%0d]: got color=%h last=%h, expected color=%h last=%h",
               n, got.color, got.last, exp.color, exp.last);
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      mismatch_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

task automatic issue_request(input logic [15:0] text, input logic [15:0] attr,
                             input logic [2:0] scan);
   int waited;
   waited = 0;
   @(negedge sys_clk);
   while (!req_ready && waited < REQ_TIMEOUT) begin
      @(negedge sys_clk);
      waited++;
   end
   if (!req_ready) begin
      other_count++;
      $display("timeout: renderer never became ready for a request");
   end else begin
      req       = '{text, attr, scan};
      req_valid = 1'b1;
      @(negedge sys_clk);   // taken on the edge in between
      req_valid = 1'b0;
   end
endtask

task automatic collect_row(input bit rand_ready);
   int n;
   int waited;
   int r;
   n      = 0;
   waited = 0;
   while (n < 8 * LC && waited < PIX_TIMEOUT) begin
      @(negedge sys_clk);
      r         = $random(seed);
      pix_ready = rand_ready ? r[0] : 1'b1;
      if (pix_valid && pix_ready) begin
         check_pix(n, pix, expected_pix(n));
         n++;
         waited = 0;
      end else begin
         waited++;
      end
   end
   pix_ready = 1'b1;
   if (n < 8 * LC) begin
      other_count++;
      $display("timeout: only %0d of %0d pixels arrived", n, 8 * LC);
   end else begin
      @(negedge sys_clk);
      check_flag("pix_valid after last pixel", pix_valid, 1'b0);
   end
endtask

task automatic render_row(input logic [15:0] text, input logic [15:0] attr,
                          input logic [2:0] scan, input bit rand_ready);
   row_text = text;
   row_attr = attr;
   row_scan = scan;
   issue_request(text, attr, scan);
   collect_row(rand_ready);
endtask

`endif

/* test/tb_chroni_text.sv */
`timescale 1ns/1ps

module tb_chroni_text;
   import chroni_cfg_pkg::*;
   import chroni_types_pkg::*;

   localparam int LC          = DEF_LINE_CHARS;
   localparam int AW          = DEF_VRAM_AW;
   localparam int REQ_TIMEOUT = 100;
   localparam int PIX_TIMEOUT = 200;   // cycles per pixel

   logic       sys_clk;
   logic       rst_n;
   cpu_wr_t    cpu;
   line_req_t  req;
   logic       req_valid;
   logic       req_ready;
   pix_out_t   pix;
   logic       pix_valid;
   logic       pix_ready;

   // reference model state
   logic [7:0]         vram_model [2**AW];
   logic [COLOR_W-1:0] pal_model [2**PAL_IW];
   logic [AW-1:0]      vram_ptr;
   logic [PAL_IW-1:0]  pal_ptr;
   logic [7:0]         pal_lo;
   logic               pal_hi_next;
   logic [7:0]         charset_model;
   logic [15:0]        row_text;
   logic [15:0]        row_attr;
   logic [2:0]         row_scan;

   integer seed = 32'hc0a083f5;
   int     mismatch_count = 0;
   int     other_count = 0;

   chroni_text #(
      .LINE_CHARS (LC),
      .VRAM_AW    (AW)
   ) chroni_text_i (
      .sys_clk   (sys_clk),
      .rst_n     (rst_n),
      .cpu       (cpu),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .pix       (pix),
      .pix_valid (pix_valid),
      .pix_ready (pix_ready)
   );

   `include "chroni_tb_tasks.svh"

   initial begin
      sys_clk = 1'b0;
      forever #20 sys_clk = ~sys_clk;
   end

   task automatic render_random_font();
      int r;
      fill_vram();   // text, attributes and font all come through the data port
      write_reg(REG_PAL_INDEX, 8'h00);
      for (int i = 0; i < 2**PAL_IW; i++) begin
         r = $random(seed);
         write_pal_pair(r[15:0]);
      end
      write_reg(REG_CHARSET, 8'h01);
      bus_idle();
      render_row(16'h0010, 16'h0020, 3'd0, 1'b0);
   endtask

   task automatic pal_index_autoinc();
      write_reg(REG_PAL_INDEX, 8'h05);
      for (int i = 0; i < 4; i++) begin
         write_pal_pair(16'(16'h0f00 + i * 16'h1011));
      end
      set_vram_addr(16'h0000);
      write_reg(REG_VRAM_DATA, 8'hF0);   // code 0, scanline 0
      set_vram_addr(16'h0060);
      for (int i = 0; i < LC; i++) begin
         write_reg(REG_VRAM_DATA, 8'h00);
      end
      set_vram_addr(16'h0070);
      for (int i = 0; i < LC; i++) begin
         write_reg(REG_VRAM_DATA, {4'(5 + (i + 1) % 4), 4'(5 + i % 4)});
      end
      write_reg(REG_CHARSET, 8'h00);
      bus_idle();
      render_row(16'h0060, 16'h0070, 3'd0, 1'b0);
   endtask

   task automatic attr_nibble_split();
      set_vram_addr(16'h0008);
      write_reg(REG_VRAM_DATA, 8'hAA);   // code 1
      set_vram_addr(16'h0010);
      write_reg(REG_VRAM_DATA, 8'h0F);   // code 2
      set_vram_addr(16'h0080);
      for (int i = 0; i < LC; i++) begin
         write_reg(REG_VRAM_DATA, 8'(1 + i % 2));
      end
      set_vram_addr(16'h0090);
      for (int i = 0; i < LC; i++) begin
         write_reg(REG_VRAM_DATA, {4'(i), 4'(15 - i)});
      end
      write_reg(REG_CHARSET, 8'h00);
      bus_idle();
      render_row(16'h0080, 16'h0090, 3'd0, 1'b0);
   endtask

   task automatic scan_and_charset();
      write_reg(REG_CHARSET, 8'h00);
      bus_idle();
      render_row(16'h0020, 16'h0030, 3'd3, 1'b0);
      render_row(16'h0020, 16'h0030, 3'd7, 1'b0);
      write_reg(REG_CHARSET, 8'h02);
      bus_idle();
      render_row(16'h0020, 16'h0030, 3'd3, 1'b0);
      write_reg(REG_CHARSET, 8'h03);   // glyph addresses wrap past the top
      bus_idle();
      render_row(16'h0020, 16'h0030, 3'd7, 1'b0);
   endtask

   task automatic ready_backpressure();
      write_reg(REG_CHARSET, 8'h01);
      bus_idle();
      render_row(16'h0100, 16'h0200, 3'd5, 1'b1);
      render_row(16'h0100, 16'h0200, 3'd5, 1'b0);
   endtask

   initial begin
      rst_n       = 1'b0;
      cpu         = '0;
      req         = '0;
      req_valid   = 1'b0;
      pix_ready   = 1'b1;
      vram_ptr    = '0;
      pal_ptr     = '0;
      pal_lo      = '0;
      pal_hi_next = 1'b0;
      charset_model = '0;
      for (int i = 0; i < 2**PAL_IW; i++) begin
         pal_model[i] = '0;
      end
      repeat (8) @(negedge sys_clk);
      rst_n = 1'b1;
      @(negedge sys_clk);
      check_flag("req_ready after reset", req_ready, 1'b1);
      check_flag("pix_valid after reset", pix_valid, 1'b0);

      render_random_font();
      pal_index_autoinc();
      attr_nibble_split();
      scan_and_charset();
      ready_backpressure();

      repeat (4) @(negedge sys_clk);
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+include
rtl/chroni_cfg_pkg.sv
rtl/chroni_types_pkg.sv
rtl/chroni_regs.sv
rtl/vram.sv
rtl/glyph_fetch.sv
rtl/palette_shader.sv
rtl/chroni_text.sv
test/tb_chroni_text.sv
